//--- hdl/dmmu_pkg.sv
package dmmu_pkg;

    // --------------------
    // Sv32 widths
    // --------------------
    localparam int PAGE_OFFSET_W = 12;
    localparam int VPN_W         = 10;
    localparam int PPN_W         = 22;

    typedef enum logic [1:0]
    {
        PRIV_USER    = 2'd0,
        PRIV_SUPER   = 2'd1,
        PRIV_MACHINE = 2'd3
    } priv_e;

    // --------------------
    // Page table entry
    // --------------------
    typedef struct packed
    {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    typedef struct packed
    {
        logic [11:0]      ppn1;
        logic [VPN_W-1:0] ppn0;
        logic [1:0]       rsw;
        pte_flags_t       flags;
    } pte_t;

    // Walker view of a virtual address
    typedef struct packed
    {
        logic [VPN_W-1:0]         vpn1;
        logic [VPN_W-1:0]         vpn0;
        logic [PAGE_OFFSET_W-1:0] offset;
    } vaddr_walk_t;

    // TLB view with one tag for both levels
    typedef struct packed
    {
        logic [2*VPN_W-1:0]       vpn;
        logic [PAGE_OFFSET_W-1:0] offset;
    } vaddr_tlb_t;

    typedef union packed
    {
        vaddr_walk_t walk;
        vaddr_tlb_t  tlb;
    } vaddr_u;

    typedef struct packed
    {
        logic             mode;
        logic [8:0]       asid;
        logic [PPN_W-1:0] ppn;
    } satp_t;

    // --------------------
    // Ports
    // --------------------
    typedef struct packed
    {
        logic        valid;
        logic        rd;
        logic [3:0]  wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed
    {
        logic        ack;
        logic        error;
        logic        load_fault;
        logic        store_fault;
        logic [31:0] data;
    } cpu_rsp_t;

    typedef struct packed
    {
        logic        valid;
        logic        rd;
        logic [3:0]  wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed
    {
        logic        ack;
        logic        error;
        logic [31:0] data;
    } mem_rsp_t;

    typedef struct packed
    {
        logic               valid;
        logic [2*VPN_W-1:0] vpn;
        pte_t               pte;
    } tlb_fill_t;

endpackage

//--- hdl/dmmu_tlb.sv
module dmmu_tlb
(
    input  logic                clk_i,
    input  logic                rst_i,
    input  dmmu_pkg::priv_e     priv_i,
    input  logic                sum_i,
    input  logic                mxr_i,
    input  logic                flush_i,
    input  logic                satp_mode_i,
    input  dmmu_pkg::cpu_req_t  cpu_req_i,
    input  dmmu_pkg::tlb_fill_t fill_i,
    output logic                miss_o,
    output dmmu_pkg::vaddr_u    miss_addr_o,
    output dmmu_pkg::mem_req_t  xlat_req_o,
    output logic                load_fault_o,
    output logic                store_fault_o
);

    logic                           entry_valid_q;
    logic [2*dmmu_pkg::VPN_W-1:0]   entry_vpn_q;
    dmmu_pkg::pte_t                 entry_pte_q;

    dmmu_pkg::vaddr_u               req_va_w;
    logic                           vm_en_w;
    logic                           entry_match_w;
    logic                           req_hit_w;
    logic                           perm_fault_r;

    // --------------------
    // Single entry
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            entry_valid_q <= 1'b0;
        else if (flush_i)
            entry_valid_q <= 1'b0;
        else if (fill_i.valid)
            entry_valid_q <= 1'b1;
    end

    always_ff @(posedge clk_i)
    begin
        if (fill_i.valid)
        begin
            entry_vpn_q <= fill_i.vpn;
            entry_pte_q <= fill_i.pte;
        end
    end

    // --------------------
    // Lookup
    // --------------------
    assign req_va_w      = cpu_req_i.addr;
    assign vm_en_w       = satp_mode_i && (priv_i != dmmu_pkg::PRIV_MACHINE);
    assign entry_match_w = entry_valid_q && (entry_vpn_q == req_va_w.tlb.vpn);
    assign req_hit_w     = cpu_req_i.valid && vm_en_w && entry_match_w;

    // Walker keeps sampling this until the fill lands
    assign miss_o      = cpu_req_i.valid && vm_en_w && !entry_match_w;
    assign miss_addr_o = req_va_w;

    // --------------------
    // Permission checks
    // --------------------
    always_comb
    begin
        perm_fault_r = 1'b0;
        if (!entry_pte_q.flags.v)
            perm_fault_r = 1'b1;
        else if (priv_i == dmmu_pkg::PRIV_SUPER && entry_pte_q.flags.u && !sum_i)
            perm_fault_r = 1'b1;
        else if (priv_i == dmmu_pkg::PRIV_USER && !entry_pte_q.flags.u)
            perm_fault_r = 1'b1;
        else if (cpu_req_i.rd)
            perm_fault_r = !(entry_pte_q.flags.r || (mxr_i && entry_pte_q.flags.x));
        else
            perm_fault_r = !(entry_pte_q.flags.r && entry_pte_q.flags.w);
    end

    assign load_fault_o  = req_hit_w && cpu_req_i.rd && perm_fault_r;
    assign store_fault_o = req_hit_w && (|cpu_req_i.wr) && perm_fault_r;

    // Bare mode leaves the request untouched
    always_comb
    begin
        xlat_req_o = cpu_req_i;
        if (vm_en_w)
        begin
            xlat_req_o.addr  = {entry_pte_q.ppn1[9:0], entry_pte_q.ppn0, req_va_w.tlb.offset};
            xlat_req_o.valid = req_hit_w && !perm_fault_r;
        end
    end

endmodule

//--- hdl/dmmu_ptw.sv
module dmmu_ptw
(
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [dmmu_pkg::PPN_W-1:0] satp_ppn_i,
    input  logic                       miss_i,
    input  dmmu_pkg::vaddr_u           miss_addr_i,
    input  logic                       walk_accept_i,
    input  dmmu_pkg::mem_rsp_t         walk_rsp_i,
    output dmmu_pkg::mem_req_t         walk_req_o,
    output dmmu_pkg::tlb_fill_t        fill_o
);

    localparam logic [1:0] STATE_IDLE   = 2'd0;
    localparam logic [1:0] STATE_LEVEL1 = 2'd1;
    localparam logic [1:0] STATE_LEVEL2 = 2'd2;
    localparam logic [1:0] STATE_UPDATE = 2'd3;

    logic [1:0]       state_q;
    logic             req_q;
    dmmu_pkg::vaddr_u va_q;
    logic [31:0]      pte_addr_q;
    dmmu_pkg::pte_t   pte_q;

    dmmu_pkg::pte_t   rsp_pte_w;
    logic             rsp_bad_w;
    logic             rsp_pointer_w;

    assign rsp_pte_w     = walk_rsp_i.data;
    assign rsp_bad_w     = walk_rsp_i.error || !rsp_pte_w.flags.v;
    assign rsp_pointer_w = !(rsp_pte_w.flags.r || rsp_pte_w.flags.w || rsp_pte_w.flags.x);

    // --------------------
    // Walk FSM
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q <= STATE_IDLE;
            req_q   <= 1'b0;
        end
        else
        begin
            // Request stays up until the arbiter takes it
            if (walk_accept_i)
                req_q <= 1'b0;

            case (state_q)
                STATE_IDLE:
                begin
                    if (miss_i)
                    begin
                        req_q   <= 1'b1;
                        state_q <= STATE_LEVEL1;
                    end
                end
                STATE_LEVEL1:
                begin
                    if (walk_rsp_i.ack)
                    begin
                        if (!rsp_bad_w && rsp_pointer_w)
                        begin
                            req_q   <= 1'b1;
                            state_q <= STATE_LEVEL2;
                        end
                        else
                            state_q <= STATE_UPDATE;
                    end
                end
                STATE_LEVEL2:
                begin
                    if (walk_rsp_i.ack)
                        state_q <= STATE_UPDATE;
                end
                default:
                    state_q <= STATE_IDLE;
            endcase
        end
    end

    // Address and entry payload
    always_ff @(posedge clk_i)
    begin
        if (state_q == STATE_IDLE && miss_i)
        begin
            va_q       <= miss_addr_i;
            pte_addr_q <= {satp_ppn_i[dmmu_pkg::PPN_W-3:0], miss_addr_i.walk.vpn1, 2'b00};
        end
        else if (state_q == STATE_LEVEL1 && walk_rsp_i.ack)
        begin
            if (rsp_bad_w)
                pte_q <= '0;
            else if (rsp_pointer_w)
                pte_addr_q <= {rsp_pte_w.ppn1[9:0], rsp_pte_w.ppn0, va_q.walk.vpn0, 2'b00};
            else
            begin
                // Superpage takes its low ppn from the request
                pte_q      <= rsp_pte_w;
                pte_q.ppn0 <= va_q.walk.vpn0;
            end
        end
        else if (state_q == STATE_LEVEL2 && walk_rsp_i.ack)
        begin
            if (rsp_bad_w)
                pte_q <= '0;
            else
                pte_q <= rsp_pte_w;
        end
    end

    // --------------------
    // Outputs
    // --------------------
    always_comb
    begin
        walk_req_o       = '0;
        walk_req_o.valid = req_q;
        walk_req_o.rd    = 1'b1;
        walk_req_o.addr  = pte_addr_q;
    end

    assign fill_o.valid = (state_q == STATE_UPDATE);
    assign fill_o.vpn   = va_q.tlb.vpn;
    assign fill_o.pte   = pte_q;

endmodule

//--- hdl/dmmu_mem_arb.sv
module dmmu_mem_arb
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  dmmu_pkg::mem_req_t walk_req_i,
    input  dmmu_pkg::mem_req_t xlat_req_i,
    input  logic               load_fault_i,
    input  logic               store_fault_i,
    input  logic               mem_accept_i,
    input  dmmu_pkg::mem_rsp_t mem_rsp_i,
    output dmmu_pkg::mem_req_t mem_req_o,
    output logic               walk_accept_o,
    output dmmu_pkg::mem_rsp_t walk_rsp_o,
    output logic               cpu_accept_o,
    output dmmu_pkg::cpu_rsp_t cpu_rsp_o
);

    logic hold_q;
    logic hold_src_walk_q;
    logic busy_q;
    logic owner_walk_q;
    logic load_fault_q;
    logic store_fault_q;

    logic src_walk_w;
    logic accept_w;
    logic walk_ack_w;
    logic cpu_ack_w;

    // --------------------
    // Source select
    // --------------------
    // Walker wins unless a stalled request is pinned
    assign src_walk_w = hold_q ? hold_src_walk_q : walk_req_i.valid;

    always_comb
    begin
        mem_req_o       = src_walk_w ? walk_req_i : xlat_req_i;
        mem_req_o.valid = mem_req_o.valid && !busy_q;
    end

    assign accept_w      = mem_req_o.valid && mem_accept_i;
    assign walk_accept_o = accept_w && src_walk_w;
    assign cpu_accept_o  = (accept_w && !src_walk_w) || load_fault_i || store_fault_i;

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            hold_q          <= 1'b0;
            hold_src_walk_q <= 1'b0;
            busy_q          <= 1'b0;
            owner_walk_q    <= 1'b0;
            load_fault_q    <= 1'b0;
            store_fault_q   <= 1'b0;
        end
        else
        begin
            if (mem_req_o.valid && !mem_accept_i)
            begin
                hold_q          <= 1'b1;
                hold_src_walk_q <= src_walk_w;
            end
            else if (accept_w)
                hold_q <= 1'b0;

            // Single outstanding access and its owner
            if (accept_w)
            begin
                busy_q       <= 1'b1;
                owner_walk_q <= src_walk_w;
            end
            else if (mem_rsp_i.ack)
                busy_q <= 1'b0;

            load_fault_q  <= load_fault_i;
            store_fault_q <= store_fault_i;
        end
    end

    // --------------------
    // Response routing
    // --------------------
    assign walk_ack_w = mem_rsp_i.ack && busy_q && owner_walk_q;
    assign cpu_ack_w  = mem_rsp_i.ack && busy_q && !owner_walk_q;

    always_comb
    begin
        walk_rsp_o     = mem_rsp_i;
        walk_rsp_o.ack = walk_ack_w;
    end

    assign cpu_rsp_o.ack         = cpu_ack_w || load_fault_q || store_fault_q;
    assign cpu_rsp_o.error       = (cpu_ack_w && mem_rsp_i.error) || load_fault_q || store_fault_q;
    assign cpu_rsp_o.load_fault  = load_fault_q;
    assign cpu_rsp_o.store_fault = store_fault_q;
    assign cpu_rsp_o.data        = mem_rsp_i.data;

endmodule

//--- hdl/dmmu_top.sv
module dmmu_top
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  dmmu_pkg::priv_e   priv_i,
    input  logic              sum_i,
    input  logic              mxr_i,
    input  logic              flush_i,
    input  dmmu_pkg::satp_t   satp_i,
    input  dmmu_pkg::cpu_req_t cpu_req_i,
    output logic              cpu_accept_o,
    output dmmu_pkg::cpu_rsp_t cpu_rsp_o,
    output dmmu_pkg::mem_req_t mem_req_o,
    input  logic              mem_accept_i,
    input  dmmu_pkg::mem_rsp_t mem_rsp_i
);

    // TLB to walker and arbiter
    logic                miss_w;
    dmmu_pkg::vaddr_u    miss_addr_w;
    dmmu_pkg::mem_req_t  xlat_req_w;
    logic                load_fault_w;
    logic                store_fault_w;

    // Walker side
    dmmu_pkg::tlb_fill_t fill_w;
    dmmu_pkg::mem_req_t  walk_req_w;
    logic                walk_accept_w;
    dmmu_pkg::mem_rsp_t  walk_rsp_w;

    dmmu_tlb dmmu_tlb_inst
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .priv_i        (priv_i),
        .sum_i         (sum_i),
        .mxr_i         (mxr_i),
        .flush_i       (flush_i),
        .satp_mode_i   (satp_i.mode),
        .cpu_req_i     (cpu_req_i),
        .fill_i        (fill_w),
        .miss_o        (miss_w),
        .miss_addr_o   (miss_addr_w),
        .xlat_req_o    (xlat_req_w),
        .load_fault_o  (load_fault_w),
        .store_fault_o (store_fault_w)
    );

    dmmu_ptw dmmu_ptw_inst
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .satp_ppn_i    (satp_i.ppn),
        .miss_i        (miss_w),
        .miss_addr_i   (miss_addr_w),
        .walk_accept_i (walk_accept_w),
        .walk_rsp_i    (walk_rsp_w),
        .walk_req_o    (walk_req_w),
        .fill_o        (fill_w)
    );

    dmmu_mem_arb dmmu_mem_arb_inst
    (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .walk_req_i    (walk_req_w),
        .xlat_req_i    (xlat_req_w),
        .load_fault_i  (load_fault_w),
        .store_fault_i (store_fault_w),
        .mem_accept_i  (mem_accept_i),
        .mem_rsp_i     (mem_rsp_i),
        .mem_req_o     (mem_req_o),
        .walk_accept_o (walk_accept_w),
        .walk_rsp_o    (walk_rsp_w),
        .cpu_accept_o  (cpu_accept_o),
        .cpu_rsp_o     (cpu_rsp_o)
    );

endmodule

//--- sim/tb_mem_model.sv
module tb_mem_model
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  dmmu_pkg::mem_req_t mem_req_i,
    output logic               mem_accept_o,
    output dmmu_pkg::mem_rsp_t mem_rsp_o,
    output int                 pte_reads_o,
    output int                 accesses_o,
    output logic [31:0]        last_addr_o
);

    // Sparse word store with the page tables in 0x0010_xxxx
    logic [31:0] mem_q [logic [29:0]];
    logic        pending_q;
    int          delay_q;
    logic [29:0] idx_q;
    logic [31:0] merge_v;

    // Unwritten words read back a pattern built from the full address
    function automatic logic [31:0] read_word(input logic [29:0] idx);
        if (mem_q.exists(idx))
            return mem_q[idx];
        return {idx[15:0], idx[29:16], 2'b01} ^ 32'h3C5A_A5C3;
    endfunction

    always @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            mem_accept_o <= 1'b0;
            mem_rsp_o    <= '0;
            pending_q    <= 1'b0;
            delay_q      <= 0;
            idx_q        <= '0;
            pte_reads_o  <= 0;
            accesses_o   <= 0;
            last_addr_o  <= '0;
        end
        else
        begin
            mem_accept_o  <= ($urandom % 4) != 0;
            mem_rsp_o.ack <= 1'b0;
            if (mem_req_i.valid && mem_accept_o)
            begin
                pending_q   <= 1'b1;
                delay_q     <= $urandom % 3;
                idx_q       <= mem_req_i.addr[31:2];
                accesses_o  <= accesses_o + 1;
                last_addr_o <= mem_req_i.addr;
                if (mem_req_i.rd && mem_req_i.addr[31:16] == 16'h0010)
                    pte_reads_o <= pte_reads_o + 1;
                if (|mem_req_i.wr)
                begin
                    merge_v = read_word(mem_req_i.addr[31:2]);
                    for (int b = 0; b < 4; b++)
                        if (mem_req_i.wr[b])
                            merge_v[8*b +: 8] = mem_req_i.wdata[8*b +: 8];
                    mem_q[mem_req_i.addr[31:2]] = merge_v;
                end
            end
            else if (pending_q)
            begin
                if (delay_q == 0)
                begin
                    pending_q       <= 1'b0;
                    mem_rsp_o.ack   <= 1'b1;
                    mem_rsp_o.error <= 1'b0;
                    mem_rsp_o.data  <= read_word(idx_q);
                end
                else
                    delay_q <= delay_q - 1;
            end
        end
    end

endmodule

//--- sim/dmmu_checker.sv
module dmmu_checker
(
    input logic               clk_i,
    input logic               rst_i,
    input dmmu_pkg::mem_req_t mem_req_i,
    input logic               mem_accept_i,
    input dmmu_pkg::mem_rsp_t mem_rsp_i,
    input dmmu_pkg::cpu_rsp_t cpu_rsp_i
);

    logic outstanding_q;

    // Own view of the single outstanding access
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            outstanding_q <= 1'b0;
        else if (mem_req_i.valid && mem_accept_i)
            outstanding_q <= 1'b1;
        else if (mem_rsp_i.ack)
            outstanding_q <= 1'b0;
    end

    req_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_req_i.valid && !mem_accept_i |=> $stable(mem_req_i))
        else $error("Memory request changed while waiting for accept");

    single_access_a: assert property (@(posedge clk_i) disable iff (rst_i)
        outstanding_q |-> !mem_req_i.valid)
        else $error("Memory request raised while an access is outstanding");

    // A faulting request never reaches the memory port
    fault_rsp_a: assert property (@(posedge clk_i) disable iff (rst_i)
        (cpu_rsp_i.load_fault || cpu_rsp_i.store_fault)
            |-> (cpu_rsp_i.ack && cpu_rsp_i.error && !$past(mem_req_i.valid)))
        else $error("Fault flag seen without ack and error, or after a memory request");

endmodule

bind dmmu_top dmmu_checker dmmu_checker_inst
(
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .mem_req_i    (mem_req_o),
    .mem_accept_i (mem_accept_i),
    .mem_rsp_i    (mem_rsp_i),
    .cpu_rsp_i    (cpu_rsp_o)
);

//--- sim/tb_dmmu.sv
module tb_dmmu;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int MARGIN_CYCLES   = 500;

    // --------------------
    // Page layout
    // --------------------
    localparam logic [21:0] ROOT_PPN  = 22'h00100;
    localparam logic [21:0] L2_PPN    = 22'h00101;
    localparam logic [21:0] PAGE_PPN  = 22'h00200;
    localparam logic [21:0] SUPER_PPN = 22'h01400;
    localparam logic [31:0] PERM_VA   = 32'h0040_2020;
    localparam logic [31:0] PERM_DATA = 32'hBEEF_0004;

    localparam logic [7:0] PTE_V = 8'h01;
    localparam logic [7:0] PTE_R = 8'h02;
    localparam logic [7:0] PTE_W = 8'h04;
    localparam logic [7:0] PTE_X = 8'h08;
    localparam logic [7:0] PTE_U = 8'h10;
    localparam logic [7:0] PTE_A = 8'h40;
    localparam logic [7:0] PTE_D = 8'h80;

    logic               clk_i = 1'b0;
    logic               rst_i;
    dmmu_pkg::priv_e    priv;
    logic               sum;
    logic               mxr;
    logic               flush;
    dmmu_pkg::satp_t    satp;
    dmmu_pkg::cpu_req_t cpu_req;
    logic               cpu_accept;
    dmmu_pkg::cpu_rsp_t cpu_rsp;
    dmmu_pkg::mem_req_t mem_req;
    logic               mem_accept;
    dmmu_pkg::mem_rsp_t mem_rsp;
    int                 pte_reads;
    int                 accesses;
    logic [31:0]        last_addr;

    int rsp_errors   = 0;
    int count_errors = 0;
    int addr_errors  = 0;
    int other_errors = 0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    dmmu_top dmmu_top_inst
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .priv_i       (priv),
        .sum_i        (sum),
        .mxr_i        (mxr),
        .flush_i      (flush),
        .satp_i       (satp),
        .cpu_req_i    (cpu_req),
        .cpu_accept_o (cpu_accept),
        .cpu_rsp_o    (cpu_rsp),
        .mem_req_o    (mem_req),
        .mem_accept_i (mem_accept),
        .mem_rsp_i    (mem_rsp)
    );

    tb_mem_model mem_model_inst
    (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .mem_req_i    (mem_req),
        .mem_accept_o (mem_accept),
        .mem_rsp_o    (mem_rsp),
        .pte_reads_o  (pte_reads),
        .accesses_o   (accesses),
        .last_addr_o  (last_addr)
    );

    // --------------------
    // Expected values
    // --------------------
    function automatic dmmu_pkg::pte_t make_pte(input logic [21:0] ppn, input logic [7:0] flags);
        dmmu_pkg::pte_t pte;
        pte.ppn1  = ppn[21:10];
        pte.ppn0  = ppn[9:0];
        pte.rsw   = 2'b00;
        pte.flags = flags;
        return pte;
    endfunction

    // Address of entry index within the table at ppn
    function automatic logic [31:0] pte_slot(input logic [21:0] ppn, input logic [9:0] index);
        return {ppn[19:0], index, 2'b00};
    endfunction

    function automatic dmmu_pkg::cpu_rsp_t ok_rsp(input logic [31:0] data);
        dmmu_pkg::cpu_rsp_t rsp;
        rsp      = '0;
        rsp.ack  = 1'b1;
        rsp.data = data;
        return rsp;
    endfunction

    function automatic dmmu_pkg::cpu_rsp_t fault_rsp(input logic is_load);
        dmmu_pkg::cpu_rsp_t rsp;
        rsp             = '0;
        rsp.ack         = 1'b1;
        rsp.error       = 1'b1;
        rsp.load_fault  = is_load;
        rsp.store_fault = !is_load;
        return rsp;
    endfunction

    // --------------------
    // Compare tasks
    // --------------------
    task automatic check_rsp(input dmmu_pkg::cpu_rsp_t got, input dmmu_pkg::cpu_rsp_t exp,
                             input logic with_data, input string what);
        if (got.ack !== exp.ack || got.error !== exp.error
            || got.load_fault !== exp.load_fault || got.store_fault !== exp.store_fault
            || (with_data && got.data !== exp.data))
        begin
            rsp_errors++;
            $display("Fail at %0t: %s: ack=%b err=%b lf=%b sf=%b data=%h", $time, what,
                     got.ack, got.error, got.load_fault, got.store_fault, got.data);
            $display("  expected ack=%b err=%b lf=%b sf=%b data=%h", exp.ack, exp.error,
                     exp.load_fault, exp.store_fault, exp.data);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp)
        begin
            count_errors++;
            $display("Fail at %0t: %s: count %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_addr(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp)
        begin
            addr_errors++;
            $display("Fail at %0t: %s: address %h, expected %h", $time, what, got, exp);
        end
    endtask

    // --------------------
    // Drivers
    // --------------------
    task automatic cpu_access(input dmmu_pkg::priv_e p, input logic rd, input logic [3:0] wr,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              output dmmu_pkg::cpu_rsp_t rsp);
        @(posedge clk_i);
        #1;
        priv          = p;
        cpu_req.valid = 1'b1;
        cpu_req.rd    = rd;
        cpu_req.wr    = wr;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        // Taken at the edge after accept is seen
        do
            @(negedge clk_i);
        while (!cpu_accept);
        @(posedge clk_i);
        #1;
        cpu_req = '0;
        do
            @(negedge clk_i);
        while (!cpu_rsp.ack);
        rsp = cpu_rsp;
    endtask

    task automatic set_ctrl(input logic mode, input logic s, input logic m);
        @(posedge clk_i);
        #1;
        satp.mode = mode;
        sum       = s;
        mxr       = m;
    endtask

    task automatic pulse_flush();
        @(posedge clk_i);
        #1;
        flush = 1'b1;
        @(posedge clk_i);
        #1;
        flush = 1'b0;
    endtask

    task automatic store_word(input dmmu_pkg::priv_e p, input logic [31:0] va,
                              input logic [31:0] data, input logic [31:0] exp_pa,
                              input string what);
        dmmu_pkg::cpu_rsp_t rsp;
        cpu_access(p, 1'b0, 4'hF, va, data, rsp);
        check_rsp(rsp, ok_rsp(data), 1'b0, what);
        check_addr(last_addr, exp_pa, what);
    endtask

    // Machine mode always bypasses translation
    task automatic mem_write(input logic [31:0] addr, input logic [31:0] data);
        store_word(dmmu_pkg::PRIV_MACHINE, addr, data, addr, "table setup store");
    endtask

    task automatic write_leaf(input logic [7:0] flags);
        mem_write(pte_slot(L2_PPN, PERM_VA[21:12]), make_pte(PAGE_PPN, flags));
    endtask

    task automatic load_expect(input dmmu_pkg::priv_e p, input logic [31:0] va,
                               input logic [31:0] exp_pa, input logic [31:0] exp_data,
                               input int exp_walk_reads, input string what);
        int                 reads0;
        dmmu_pkg::cpu_rsp_t rsp;
        reads0 = pte_reads;
        cpu_access(p, 1'b1, 4'h0, va, 32'h0, rsp);
        check_rsp(rsp, ok_rsp(exp_data), 1'b1, what);
        check_addr(last_addr, exp_pa, what);
        check_count(pte_reads - reads0, exp_walk_reads, {what, " walk reads"});
    endtask

    task automatic fault_expect(input dmmu_pkg::priv_e p, input logic is_load,
                                input int exp_walk_reads, input string what);
        int                 reads0;
        int                 acc0;
        dmmu_pkg::cpu_rsp_t rsp;
        reads0 = pte_reads;
        acc0   = accesses;
        cpu_access(p, is_load, is_load ? 4'h0 : 4'hF, PERM_VA, 32'hDEAD_BEEF, rsp);
        check_rsp(rsp, fault_rsp(is_load), 1'b0, what);
        check_count(pte_reads - reads0, exp_walk_reads, {what, " walk reads"});
        // Only the walk may reach memory
        check_count(accesses - acc0, exp_walk_reads, {what, " memory accesses"});
    endtask

    // --------------------
    // Tests
    // --------------------
    task automatic bare_mode_test();
        set_ctrl(1'b0, 1'b0, 1'b0);
        store_word(dmmu_pkg::PRIV_SUPER, 32'h0000_8010, 32'h1234_5678, 32'h0000_8010,
                   "bare store");
        load_expect(dmmu_pkg::PRIV_SUPER, 32'h0000_8010, 32'h0000_8010, 32'h1234_5678, 0,
                    "bare load");
        set_ctrl(1'b1, 1'b0, 1'b0);
        store_word(dmmu_pkg::PRIV_MACHINE, 32'h0030_0040, 32'h8765_4321, 32'h0030_0040,
                   "machine store");
        load_expect(dmmu_pkg::PRIV_MACHINE, 32'h0030_0040, 32'h0030_0040, 32'h8765_4321, 0,
                    "machine load");
    endtask

    task automatic page_walk_test();
        mem_write(pte_slot(ROOT_PPN, PERM_VA[31:22]), make_pte(L2_PPN, PTE_V));
        write_leaf(PTE_V | PTE_R | PTE_W | PTE_A | PTE_D);
        mem_write({PAGE_PPN[19:0], 12'h010}, 32'hCAFE_0001);
        mem_write({PAGE_PPN[19:0], 12'hFFC}, 32'hCAFE_0002);
        set_ctrl(1'b1, 1'b0, 1'b0);
        pulse_flush();
        load_expect(dmmu_pkg::PRIV_SUPER, 32'h0040_2010, {PAGE_PPN[19:0], 12'h010},
                    32'hCAFE_0001, 2, "4K first load");
        load_expect(dmmu_pkg::PRIV_SUPER, 32'h0040_2FFC, {PAGE_PPN[19:0], 12'hFFC},
                    32'hCAFE_0002, 0, "4K same page");
    endtask

    task automatic superpage_test();
        logic [31:0] va;
        logic [31:0] pa;
        va = 32'h00C0_7120;
        // ppn1 then vpn0 and offset from the request
        pa = {SUPER_PPN[19:10], va[21:0]};
        mem_write(pte_slot(ROOT_PPN, va[31:22]),
                  make_pte(SUPER_PPN, PTE_V | PTE_R | PTE_W | PTE_A | PTE_D));
        mem_write(pa, 32'h5EED_0003);
        pulse_flush();
        load_expect(dmmu_pkg::PRIV_SUPER, va, pa, 32'h5EED_0003, 1, "superpage load");
    endtask

    task automatic permission_test();
        logic [31:0] pa;
        pa = {PAGE_PPN[19:0], PERM_VA[11:0]};
        mem_write(pa, PERM_DATA);

        write_leaf(PTE_V | PTE_R | PTE_W | PTE_A | PTE_D);
        pulse_flush();
        fault_expect(dmmu_pkg::PRIV_USER, 1'b1, 2, "user load without U");

        write_leaf(PTE_V | PTE_R | PTE_W | PTE_U | PTE_A | PTE_D);
        pulse_flush();
        fault_expect(dmmu_pkg::PRIV_SUPER, 1'b1, 2, "supervisor load from U page");
        set_ctrl(1'b1, 1'b1, 1'b0);
        load_expect(dmmu_pkg::PRIV_SUPER, PERM_VA, pa, PERM_DATA, 0, "load with SUM");
        set_ctrl(1'b1, 1'b0, 1'b0);

        write_leaf(PTE_V | PTE_R | PTE_A | PTE_D);
        pulse_flush();
        fault_expect(dmmu_pkg::PRIV_SUPER, 1'b0, 2, "store without W");

        write_leaf(PTE_V | PTE_X | PTE_A);
        pulse_flush();
        fault_expect(dmmu_pkg::PRIV_SUPER, 1'b1, 2, "load from X-only page");
        set_ctrl(1'b1, 1'b0, 1'b1);
        load_expect(dmmu_pkg::PRIV_SUPER, PERM_VA, pa, PERM_DATA, 0, "load with MXR");
        set_ctrl(1'b1, 1'b0, 1'b0);
    endtask

    task automatic invalid_pte_test();
        write_leaf(PTE_R | PTE_W | PTE_A | PTE_D);
        pulse_flush();
        fault_expect(dmmu_pkg::PRIV_SUPER, 1'b1, 2, "load through invalid PTE");
        write_leaf(PTE_V | PTE_R | PTE_W | PTE_A | PTE_D);
        // Zero entry still cached
        fault_expect(dmmu_pkg::PRIV_SUPER, 1'b1, 0, "stale entry before flush");
        pulse_flush();
        load_expect(dmmu_pkg::PRIV_SUPER, PERM_VA, {PAGE_PPN[19:0], PERM_VA[11:0]}, PERM_DATA,
                    2, "load after flush");
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial
    begin
        void'($urandom(92));
        rst_i     = 1'b1;
        priv      = dmmu_pkg::PRIV_MACHINE;
        sum       = 1'b0;
        mxr       = 1'b0;
        flush     = 1'b0;
        satp      = '0;
        satp.ppn  = ROOT_PPN;
        cpu_req   = '0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        if (cpu_accept || cpu_rsp.ack || mem_req.valid)
        begin
            other_errors++;
            $display("Fail at %0t: outputs not idle after reset", $time);
        end

        bare_mode_test();
        page_walk_test();
        superpage_test();
        permission_test();
        invalid_pte_test();

        $display("Errors: %0d response, %0d count, %0d address, %0d other",
                 rsp_errors, count_errors, addr_errors, other_errors);
        if (rsp_errors + count_errors + addr_errors + other_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(CLK_PERIOD * (16 + NUM_TESTS * CYCLES_PER_TEST + MARGIN_CYCLES));
        $display("Timeout: the DUT did not finish the tests in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- verilog.f
hdl/dmmu_pkg.sv
hdl/dmmu_tlb.sv
hdl/dmmu_ptw.sv
hdl/dmmu_mem_arb.sv
hdl/dmmu_top.sv
sim/tb_mem_model.sv
sim/dmmu_checker.sv
sim/tb_dmmu.sv

//--- Makefile
SRCS := $(shell cat verilog.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_dmmu: verilog.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dmmu -f verilog.f

run: obj_dir/Vtb_dmmu
	./obj_dir/Vtb_dmmu > sim.log 2>&1; cat sim.log
	grep -q "^Simulation PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
